// File: mmu_cfg.svh
/* MMU configuration */
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// Sv39 address widths
`define MMU_VLEN 39
`define MMU_PLEN 56
`define MMU_PPNW 44
`define MMU_ASIDW 16

// data TLB size
`define MMU_TLB_ENTRIES 4

// PTE memory port
`define MMU_MEM_CREDITS 2
`define MMU_PTE_W 64

// page table shape
`define MMU_LEVELS 3
`define MMU_PAGE_OFFS 12
`define MMU_VPN_IDXW 9

`endif

// File: mmu_pkg.sv
/* translation types */
`default_nettype none
`include "mmu_cfg.svh"

package mmu_pkg;

  // privilege of the load/store access
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1
  } priv_lvl_e;

  // exception cause codes as in the privileged spec
  typedef enum logic [3:0] {
    EXC_NONE             = 4'd0,
    EXC_LOAD_PAGE_FAULT  = 4'd13,
    EXC_STORE_PAGE_FAULT = 4'd15
  } exc_cause_e;

  // PTE flag byte, v sits in bit 0
  typedef struct packed {
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_flags_t;

  // page size, also the walk level it was found at
  typedef enum logic [1:0] {
    LVL_1G = 2'd0,
    LVL_2M = 2'd1,
    LVL_4K = 2'd2
  } page_lvl_e;

  typedef logic [`MMU_PPNW-1:0] ppn_t;
  typedef logic [`MMU_VLEN-`MMU_PAGE_OFFS-1:0] vpn_t;

endpackage

`default_nettype wire

// File: ptw_pkg.sv
/* walker types */
`default_nettype none
`include "mmu_cfg.svh"

package ptw_pkg;

  // walker states
  typedef enum logic [2:0] {
    PTW_IDLE,
    PTW_WAIT_CREDIT,
    PTW_WAIT_RSP,
    PTW_REFILL,
    PTW_FAULT
  } ptw_state_e;

  // byte address of a PTE read
  typedef logic [`MMU_PLEN-1:0] mem_addr_t;

  // credit counter, holds 0 up to the reset value
  typedef logic [$clog2(`MMU_MEM_CREDITS+1)-1:0] credit_t;

endpackage

`default_nettype wire

// File: mmu_tlb.sv
/* data TLB */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cfg.svh"

module mmu_tlb (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic [`MMU_ASIDW-1:0]     flush_asid_i,
  input  logic                      lu_access_i,
  input  logic [`MMU_VLEN-1:0]      lu_vaddr_i,
  input  logic [`MMU_ASIDW-1:0]     lu_asid_i,
  input  logic                      upd_valid_i,
  input  mmu_pkg::vpn_t             upd_vpn_i,
  input  logic [`MMU_ASIDW-1:0]     upd_asid_i,
  input  mmu_pkg::ppn_t             upd_ppn_i,
  input  mmu_pkg::page_lvl_e        upd_lvl_i,
  input  mmu_pkg::pte_flags_t       upd_flags_i,
  output logic                      lu_hit_o,
  output mmu_pkg::ppn_t             lu_ppn_o,
  output mmu_pkg::page_lvl_e        lu_lvl_o,
  output mmu_pkg::pte_flags_t       lu_flags_o
);

  localparam int unsigned N    = `MMU_TLB_ENTRIES;
  localparam int unsigned IDXW = (N > 1) ? $clog2(N) : 1;

  // tag and data arrays
  logic [N-1:0]          valid_q;
  mmu_pkg::vpn_t         vpn_q   [N];
  logic [`MMU_ASIDW-1:0] asid_q  [N];
  mmu_pkg::ppn_t         ppn_q   [N];
  mmu_pkg::page_lvl_e    lvl_q   [N];
  mmu_pkg::pte_flags_t   flags_q [N];

  logic [N-1:0]    match;
  logic [IDXW-1:0] rr_q;
  logic [IDXW-1:0] victim;
  logic            found_free;
  mmu_pkg::vpn_t   lu_vpn;

  assign lu_vpn = lu_vaddr_i[`MMU_VLEN-1:`MMU_PAGE_OFFS];

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  // lower vpn fields are ignored for superpages
  always_comb begin
    for (int i = 0; i < N; i++) begin
      match[i] = valid_q[i]
          && (vpn_q[i][26:18] == lu_vpn[26:18])
          && ((lvl_q[i] == mmu_pkg::LVL_1G) || (vpn_q[i][17:9] == lu_vpn[17:9]))
          && ((lvl_q[i] != mmu_pkg::LVL_4K) || (vpn_q[i][8:0] == lu_vpn[8:0]))
          && (flags_q[i].g || (asid_q[i] == lu_asid_i));
    end
  end

  assign lu_hit_o = lu_access_i && (|match);

  // at most one entry matches so a priority pick is enough
  always_comb begin
    lu_ppn_o   = '0;
    lu_lvl_o   = mmu_pkg::LVL_4K;
    lu_flags_o = '0;
    for (int i = 0; i < N; i++) begin
      if (match[i]) begin
        lu_ppn_o   = ppn_q[i];
        lu_lvl_o   = lvl_q[i];
        lu_flags_o = flags_q[i];
      end
    end
  end

  // ----------------------------------------
  // replacement
  // ----------------------------------------
  // lowest free entry wins, else the round-robin pointer
  always_comb begin
    victim     = rr_q;
    found_free = 1'b0;
    for (int i = N - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        victim     = IDXW'(i);
        found_free = 1'b1;
      end
    end
  end

  // valid bits and pointer, flush beats refill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_i) begin
      for (int i = 0; i < N; i++) begin
        // asid zero drops all, otherwise only non-global entries of that asid
        if ((flush_asid_i == '0) || ((asid_q[i] == flush_asid_i) && !flags_q[i].g)) begin
          valid_q[i] <= 1'b0;
        end
      end
    end else if (upd_valid_i) begin
      valid_q[victim] <= 1'b1;
      if (!found_free) begin
        rr_q <= (rr_q == IDXW'(N - 1)) ? '0 : rr_q + 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (upd_valid_i && !flush_i) begin
      vpn_q[victim]   <= upd_vpn_i;
      asid_q[victim]  <= upd_asid_i;
      ppn_q[victim]   <= upd_ppn_i;
      lvl_q[victim]   <= upd_lvl_i;
      flags_q[victim] <= upd_flags_i;
    end
  end

  // a refill never creates an alias of a live entry
  a_one_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lu_access_i |-> $onehot0(match));

endmodule

`default_nettype wire

// File: mmu_ptw.sv
/* Sv39 page table walker */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cfg.svh"

module mmu_ptw (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_translation_i,
  input  mmu_pkg::ppn_t             satp_ppn_i,
  input  logic [`MMU_ASIDW-1:0]     asid_i,
  input  logic                      lu_access_i,
  input  logic                      lu_hit_i,
  input  logic [`MMU_VLEN-1:0]      lu_vaddr_i,
  input  logic                      mem_credit_i,
  input  logic                      mem_rsp_valid_i,
  input  logic [`MMU_PTE_W-1:0]     mem_rsp_pte_i,
  input  logic                      flush_i,
  output logic                      mem_req_valid_o,
  output ptw_pkg::mem_addr_t        mem_req_addr_o,
  output logic                      upd_valid_o,
  output mmu_pkg::vpn_t             upd_vpn_o,
  output logic [`MMU_ASIDW-1:0]     upd_asid_o,
  output mmu_pkg::ppn_t             upd_ppn_o,
  output mmu_pkg::page_lvl_e        upd_lvl_o,
  output mmu_pkg::pte_flags_t       upd_flags_o,
  output logic                      ptw_fault_o,
  output logic                      dtlb_miss_o
);

  ptw_pkg::ptw_state_e state_q, state_d;
  mmu_pkg::page_lvl_e  lvl_q, lvl_d;
  ptw_pkg::credit_t    credit_q, credit_d;

  // walk payload
  mmu_pkg::vpn_t       vpn_q;
  mmu_pkg::ppn_t       tbl_ppn_q;
  mmu_pkg::pte_flags_t flags_q;

  logic [`MMU_VPN_IDXW-1:0] vpn_idx;
  mmu_pkg::pte_flags_t      pte_flags;
  mmu_pkg::ppn_t            pte_ppn;
  logic                     pte_leaf;
  logic                     pte_misaligned;
  logic                     pte_bad;
  logic                     start_walk;
  logic                     last_lvl;

  // miss seen while idle, walk begins next cycle
  assign start_walk = (state_q == ptw_pkg::PTW_IDLE) && en_translation_i
      && lu_access_i && !lu_hit_i && !flush_i;
  assign dtlb_miss_o = start_walk;

  // ----------------------------------------
  // PTE decode
  // ----------------------------------------
  assign pte_flags = mmu_pkg::pte_flags_t'(mem_rsp_pte_i[7:0]);
  assign pte_ppn   = mem_rsp_pte_i[53:10];
  assign pte_leaf  = pte_flags.r || pte_flags.x;
  assign last_lvl  = (lvl_q == mmu_pkg::page_lvl_e'(`MMU_LEVELS - 1));

  // superpage ppn must be aligned to its size
  assign pte_misaligned = ((lvl_q == mmu_pkg::LVL_1G) && (|pte_ppn[17:0]))
      || ((lvl_q == mmu_pkg::LVL_2M) && (|pte_ppn[8:0]));

  // A is never set by hardware here, a clear A faults
  assign pte_bad = !pte_flags.v || (pte_flags.w && !pte_flags.r)
      || (pte_leaf && (pte_misaligned || !pte_flags.a))
      || (!pte_leaf && last_lvl);

  // vpn slice indexing the current table
  always_comb begin
    unique case (lvl_q)
      mmu_pkg::LVL_1G: vpn_idx = vpn_q[26:18];
      mmu_pkg::LVL_2M: vpn_idx = vpn_q[17:9];
      default:         vpn_idx = vpn_q[8:0];
    endcase
  end

  // table base plus index times 8
  assign mem_req_addr_o = {tbl_ppn_q, vpn_idx, 3'b000};

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_d         = state_q;
    lvl_d           = lvl_q;
    mem_req_valid_o = 1'b0;
    upd_valid_o     = 1'b0;
    ptw_fault_o     = 1'b0;
    unique case (state_q)
      ptw_pkg::PTW_IDLE: begin
        if (start_walk) begin
          state_d = ptw_pkg::PTW_WAIT_CREDIT;
          lvl_d   = mmu_pkg::LVL_1G;
        end
      end
      ptw_pkg::PTW_WAIT_CREDIT: begin
        // one read in flight at a time
        if (credit_q != '0) begin
          mem_req_valid_o = 1'b1;
          state_d         = ptw_pkg::PTW_WAIT_RSP;
        end
      end
      ptw_pkg::PTW_WAIT_RSP: begin
        if (mem_rsp_valid_i) begin
          if (pte_bad) begin
            state_d = ptw_pkg::PTW_FAULT;
          end else if (pte_leaf) begin
            state_d = ptw_pkg::PTW_REFILL;
          end else begin
            // pointer to the next level table
            state_d = ptw_pkg::PTW_WAIT_CREDIT;
            lvl_d   = mmu_pkg::page_lvl_e'(lvl_q + 2'd1);
          end
        end
      end
      ptw_pkg::PTW_REFILL: begin
        upd_valid_o = 1'b1;
        state_d     = ptw_pkg::PTW_IDLE;
      end
      ptw_pkg::PTW_FAULT: begin
        ptw_fault_o = 1'b1;
        state_d     = ptw_pkg::PTW_IDLE;
      end
      default: state_d = ptw_pkg::PTW_IDLE;
    endcase
  end

  // credits: spend on request, get back on mem_credit_i
  assign credit_d = credit_q + ptw_pkg::credit_t'(mem_credit_i)
      - ptw_pkg::credit_t'(mem_req_valid_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ptw_pkg::PTW_IDLE;
      lvl_q    <= mmu_pkg::LVL_1G;
      credit_q <= ptw_pkg::credit_t'(`MMU_MEM_CREDITS);
    end else begin
      state_q  <= state_d;
      lvl_q    <= lvl_d;
      credit_q <= credit_d;
    end
  end

  // tbl_ppn_q holds the table base, then the leaf ppn
  always_ff @(posedge clk_i) begin
    if (start_walk) begin
      vpn_q     <= lu_vaddr_i[`MMU_VLEN-1:`MMU_PAGE_OFFS];
      tbl_ppn_q <= satp_ppn_i;
    end else if ((state_q == ptw_pkg::PTW_WAIT_RSP) && mem_rsp_valid_i && !pte_bad) begin
      tbl_ppn_q <= pte_ppn;
      flags_q   <= pte_flags;
    end
  end

  // refill data
  assign upd_vpn_o   = vpn_q;
  assign upd_asid_o  = asid_i;
  assign upd_ppn_o   = tbl_ppn_q;
  assign upd_lvl_o   = lvl_q;
  assign upd_flags_o = flags_q;

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  a_req_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o |-> (credit_q != '0));

  // environment returns no more credits than were taken
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= ptw_pkg::credit_t'(`MMU_MEM_CREDITS));

  a_flush_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> (state_q == ptw_pkg::PTW_IDLE));

endmodule

`default_nettype wire

// File: mmu_check.sv
/* load/store result stage */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cfg.svh"

module mmu_check (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_translation_i,
  input  mmu_pkg::priv_lvl_e     priv_lvl_i,
  input  logic                   sum_i,
  input  logic                   lsu_req_i,
  input  logic [`MMU_VLEN-1:0]   lsu_vaddr_i,
  input  logic                   lsu_is_store_i,
  input  logic                   lu_hit_i,
  input  mmu_pkg::ppn_t          lu_ppn_i,
  input  mmu_pkg::page_lvl_e     lu_lvl_i,
  input  mmu_pkg::pte_flags_t    lu_flags_i,
  input  logic                   ptw_fault_i,
  output logic                   lsu_valid_o,
  output logic [`MMU_PLEN-1:0]   lsu_paddr_o,
  output mmu_pkg::exc_cause_e    lsu_cause_o,
  output mmu_pkg::ppn_t          lsu_dtlb_ppn_o
);

  // superpages take the low vpn fields from the vaddr
  function automatic mmu_pkg::ppn_t merge_ppn(mmu_pkg::ppn_t ppn, mmu_pkg::vpn_t vpn,
                                              mmu_pkg::page_lvl_e lvl);
    mmu_pkg::ppn_t res;
    res = ppn;
    if (lvl == mmu_pkg::LVL_2M) begin
      res[8:0] = vpn[8:0];
    end
    if (lvl == mmu_pkg::LVL_1G) begin
      res[17:0] = vpn[17:0];
    end
    return res;
  endfunction

  // registered request and lookup
  logic                 req_q, hit_q, store_q;
  logic [`MMU_VLEN-1:0] vaddr_q;
  mmu_pkg::ppn_t        ppn_q;
  mmu_pkg::page_lvl_e   lvl_q;
  mmu_pkg::pte_flags_t  flags_q;
  logic                 perm_fault;
  mmu_pkg::exc_cause_e  pf_cause;

  // a request is taken once, not again in its own result cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      req_q <= lsu_req_i && !lsu_valid_o;
      hit_q <= lu_hit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q <= lsu_vaddr_i;
    store_q <= lsu_is_store_i;
    ppn_q   <= lu_ppn_i;
    lvl_q   <= lu_lvl_i;
    flags_q <= lu_flags_i;
  end

  // ----------------------------------------
  // permission check
  // ----------------------------------------
  // u page from u mode, s access to u page only with sum,
  // store needs W and D, load needs R
  assign perm_fault = ((priv_lvl_i == mmu_pkg::PRIV_U) && !flags_q.u)
      || ((priv_lvl_i == mmu_pkg::PRIV_S) && flags_q.u && !sum_i)
      || (store_q && (!flags_q.w || !flags_q.d))
      || (!store_q && !flags_q.r);

  assign pf_cause = store_q ? mmu_pkg::EXC_STORE_PAGE_FAULT : mmu_pkg::EXC_LOAD_PAGE_FAULT;

  // cycle 1 result
  always_comb begin
    lsu_valid_o = req_q;
    lsu_paddr_o = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, vaddr_q};
    lsu_cause_o = mmu_pkg::EXC_NONE;
    if (en_translation_i) begin
      lsu_paddr_o = {merge_ppn(ppn_q, vaddr_q[`MMU_VLEN-1:`MMU_PAGE_OFFS], lvl_q),
                     vaddr_q[`MMU_PAGE_OFFS-1:0]};
      // hit result, or the walker gave up on this request
      lsu_valid_o = (req_q && hit_q) || ptw_fault_i;
      if (ptw_fault_i || (req_q && hit_q && perm_fault)) begin
        lsu_cause_o = pf_cause;
      end
    end
  end

  // cycle 0 ppn, straight from the lookup
  assign lsu_dtlb_ppn_o = en_translation_i
      ? merge_ppn(lu_ppn_i, lsu_vaddr_i[`MMU_VLEN-1:`MMU_PAGE_OFFS], lu_lvl_i)
      : mmu_pkg::ppn_t'(lsu_vaddr_i[`MMU_VLEN-1:`MMU_PAGE_OFFS]);

  // walker faults only while a missed request is held
  a_fault_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ptw_fault_i |-> (req_q && !hit_q));

endmodule

`default_nettype wire

// File: mmu_top.sv
/* load/store MMU top */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cfg.svh"

module mmu_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // translation control
  input  logic                      en_translation_i,
  input  mmu_pkg::priv_lvl_e        priv_lvl_i,
  input  logic                      sum_i,
  input  mmu_pkg::ppn_t             satp_ppn_i,
  input  logic [`MMU_ASIDW-1:0]     asid_i,
  input  logic                      flush_tlb_i,
  input  logic [`MMU_ASIDW-1:0]     flush_asid_i,
  // LSU side
  input  logic                      lsu_req_i,
  input  logic [`MMU_VLEN-1:0]      lsu_vaddr_i,
  input  logic                      lsu_is_store_i,
  output logic                      lsu_dtlb_hit_o,
  output mmu_pkg::ppn_t             lsu_dtlb_ppn_o,
  output logic                      lsu_valid_o,
  output logic [`MMU_PLEN-1:0]      lsu_paddr_o,
  output mmu_pkg::exc_cause_e       lsu_cause_o,
  output logic                      dtlb_miss_o,
  // PTE memory port
  output logic                      mem_req_valid_o,
  output ptw_pkg::mem_addr_t        mem_req_addr_o,
  input  logic                      mem_rsp_valid_i,
  input  logic [`MMU_PTE_W-1:0]     mem_rsp_pte_i,
  input  logic                      mem_credit_i
);

  // lookup result
  logic                  lu_hit;
  mmu_pkg::ppn_t         lu_ppn;
  mmu_pkg::page_lvl_e    lu_lvl;
  mmu_pkg::pte_flags_t   lu_flags;

  // refill from the walker
  logic                  upd_valid;
  mmu_pkg::vpn_t         upd_vpn;
  logic [`MMU_ASIDW-1:0] upd_asid;
  mmu_pkg::ppn_t         upd_ppn;
  mmu_pkg::page_lvl_e    upd_lvl;
  mmu_pkg::pte_flags_t   upd_flags;
  logic                  ptw_fault;

  // bare mode is always ready
  assign lsu_dtlb_hit_o = en_translation_i ? lu_hit : 1'b1;

  mmu_tlb u_tlb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_tlb_i),
    .flush_asid_i (flush_asid_i),
    .lu_access_i  (lsu_req_i),
    .lu_vaddr_i   (lsu_vaddr_i),
    .lu_asid_i    (asid_i),
    .upd_valid_i  (upd_valid),
    .upd_vpn_i    (upd_vpn),
    .upd_asid_i   (upd_asid),
    .upd_ppn_i    (upd_ppn),
    .upd_lvl_i    (upd_lvl),
    .upd_flags_i  (upd_flags),
    .lu_hit_o     (lu_hit),
    .lu_ppn_o     (lu_ppn),
    .lu_lvl_o     (lu_lvl),
    .lu_flags_o   (lu_flags)
  );

  mmu_ptw u_ptw (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .en_translation_i (en_translation_i),
    .satp_ppn_i       (satp_ppn_i),
    .asid_i           (asid_i),
    .lu_access_i      (lsu_req_i),
    .lu_hit_i         (lu_hit),
    .lu_vaddr_i       (lsu_vaddr_i),
    .mem_credit_i     (mem_credit_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .mem_rsp_pte_i    (mem_rsp_pte_i),
    .flush_i          (flush_tlb_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .upd_valid_o      (upd_valid),
    .upd_vpn_o        (upd_vpn),
    .upd_asid_o       (upd_asid),
    .upd_ppn_o        (upd_ppn),
    .upd_lvl_o        (upd_lvl),
    .upd_flags_o      (upd_flags),
    .ptw_fault_o      (ptw_fault),
    .dtlb_miss_o      (dtlb_miss_o)
  );

  mmu_check u_check (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .en_translation_i (en_translation_i),
    .priv_lvl_i       (priv_lvl_i),
    .sum_i            (sum_i),
    .lsu_req_i        (lsu_req_i),
    .lsu_vaddr_i      (lsu_vaddr_i),
    .lsu_is_store_i   (lsu_is_store_i),
    .lu_hit_i         (lu_hit),
    .lu_ppn_i         (lu_ppn),
    .lu_lvl_i         (lu_lvl),
    .lu_flags_i       (lu_flags),
    .ptw_fault_i      (ptw_fault),
    .lsu_valid_o      (lsu_valid_o),
    .lsu_paddr_o      (lsu_paddr_o),
    .lsu_cause_o      (lsu_cause_o),
    .lsu_dtlb_ppn_o   (lsu_dtlb_ppn_o)
  );

endmodule

`default_nettype wire

// File: tb_mmu.sv
/* load/store MMU testbench */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cfg.svh"

module tb_mmu;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    en_translation_i;
  mmu_pkg::priv_lvl_e      priv_lvl_i;
  logic                    sum_i;
  mmu_pkg::ppn_t           satp_ppn_i;
  logic [`MMU_ASIDW-1:0]   asid_i;
  logic                    flush_tlb_i;
  logic [`MMU_ASIDW-1:0]   flush_asid_i;
  logic                    lsu_req_i;
  logic [`MMU_VLEN-1:0]    lsu_vaddr_i;
  logic                    lsu_is_store_i;
  logic                    lsu_dtlb_hit_o;
  mmu_pkg::ppn_t           lsu_dtlb_ppn_o;
  logic                    lsu_valid_o;
  logic [`MMU_PLEN-1:0]    lsu_paddr_o;
  mmu_pkg::exc_cause_e     lsu_cause_o;
  logic                    dtlb_miss_o;
  logic                    mem_req_valid_o;
  ptw_pkg::mem_addr_t      mem_req_addr_o;
  logic                    mem_rsp_valid_i;
  logic [`MMU_PTE_W-1:0]   mem_rsp_pte_i;
  logic                    mem_credit_i;

  // page table image, unmapped addresses read as zero
  logic [`MMU_PTE_W-1:0] pte_mem [logic [`MMU_PLEN-1:0]];

  int errs = 0;
  int n_run = 0;
  int n_fail = 0;
  int limit = 100000;
  int cyc;

  mmu_top mmu_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  // response 1..4 cycles after the request, credit 0..3 cycles after that
  initial begin : mem_model
    int rsp_left;
    int mcyc;
    int due;
    int last_due;
    int due_q[$];
    logic [`MMU_PLEN-1:0] addr;
    void'($urandom(32'hc410bab0));
    mem_rsp_valid_i = 1'b0;
    mem_rsp_pte_i   = '0;
    mem_credit_i    = 1'b0;
    rsp_left = 0;
    mcyc     = 0;
    last_due = 0;
    forever begin
      @(negedge clk_i);
      if (mem_req_valid_o) begin
        addr     = mem_req_addr_o;
        rsp_left = $urandom_range(4, 1);
      end
      @(posedge clk_i);
      mcyc++;
      mem_rsp_valid_i <= 1'b0;
      mem_credit_i    <= 1'b0;
      if (rsp_left > 0) begin
        rsp_left--;
        if (rsp_left == 0) begin
          mem_rsp_valid_i <= 1'b1;
          mem_rsp_pte_i   <= pte_mem.exists(addr) ? pte_mem[addr] : '0;
          // credits go back in order, at most one per cycle
          due = mcyc + $urandom_range(3, 0);
          if (due <= last_due) due = last_due + 1;
          last_due = due;
          due_q.push_back(due);
        end
      end
      if ((due_q.size() > 0) && (due_q[0] == mcyc)) begin
        mem_credit_i <= 1'b1;
        void'(due_q.pop_front());
      end
    end
  end

  task automatic show_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
    errs++;
  endtask

  task automatic set_mode(input logic en, input mmu_pkg::ppn_t ppn,
                          input logic [`MMU_ASIDW-1:0] asid);
    @(posedge clk_i);
    en_translation_i <= en;
    satp_ppn_i       <= ppn;
    asid_i           <= asid;
  endtask

  // one-cycle flush, asid zero drops everything
  task automatic flush_tlb(input logic [`MMU_ASIDW-1:0] asid);
    @(posedge clk_i);
    flush_tlb_i  <= 1'b1;
    flush_asid_i <= asid;
    @(posedge clk_i);
    flush_tlb_i  <= 1'b0;
  endtask

  // ----------------------------------------
  // request and result checks
  // ----------------------------------------
  task automatic run_request(input logic [`MMU_VLEN-1:0] va, input logic st,
                             input logic [1:0] pv, input logic sm, input logic exp_hit,
                             input logic [`MMU_PLEN-1:0] exp_pa, input logic [3:0] exp_cause);
    int            lat;
    int            misses;
    int            reads;
    int            errs_in;
    logic          hit0;
    logic          done;
    mmu_pkg::ppn_t ppn0;
    errs_in = errs;
    lat     = 0;
    misses  = 0;
    reads   = 0;
    done    = 1'b0;
    @(posedge clk_i);
    lsu_req_i      <= 1'b1;
    lsu_vaddr_i    <= va;
    lsu_is_store_i <= st;
    priv_lvl_i     <= mmu_pkg::priv_lvl_e'(pv);
    sum_i          <= sm;
    @(negedge clk_i);
    // same-cycle lookup view
    hit0 = lsu_dtlb_hit_o;
    ppn0 = lsu_dtlb_ppn_o;
    while (!done) begin
      if (dtlb_miss_o) misses++;
      if (mem_req_valid_o) reads++;
      if (lsu_valid_o) begin
        done = 1'b1;
      end else begin
        @(negedge clk_i);
        lat++;
      end
    end
    if (lsu_cause_o != exp_cause) show_mismatch("lsu_cause_o", lsu_cause_o, exp_cause);
    // paddr means nothing on a fault
    if ((exp_cause == 4'd0) && (lsu_paddr_o != exp_pa)) begin
      show_mismatch("lsu_paddr_o", lsu_paddr_o, exp_pa);
    end
    if (hit0 != exp_hit) show_mismatch("lsu_dtlb_hit_o", hit0, exp_hit);
    if (exp_hit) begin
      if (lat != 1) show_mismatch("lsu_valid_o latency", lat, 1);
      if (reads != 0) show_mismatch("mem_req_valid_o count", reads, 0);
      if ((exp_cause == 4'd0) && (ppn0 != exp_pa[`MMU_PLEN-1:`MMU_PAGE_OFFS])) begin
        show_mismatch("lsu_dtlb_ppn_o", ppn0, exp_pa[`MMU_PLEN-1:`MMU_PAGE_OFFS]);
      end
    end
    if (misses != (exp_hit ? 0 : 1)) show_mismatch("dtlb_miss_o pulses", misses, !exp_hit);
    @(posedge clk_i);
    lsu_req_i <= 1'b0;
    n_run++;
    if (errs != errs_in) n_fail++;
    $display("req %0d va %h st %0d -> %s", n_run, va, st, (errs == errs_in) ? "ok" : "FAILED");
  endtask

  // ends the run if the DUT stops answering
  initial begin : watchdog
    cyc = 0;
    while (cyc <= limit) begin
      @(posedge clk_i);
      cyc++;
    end
    $display("timeout after %0d cycles, a request got no result", cyc);
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    int          fd;
    int          n_req;
    string       line;
    string       tag;
    string       cmds[$];
    logic [63:0] v1, v2, v3, v4, v5, v6, v7;
    rst_ni           = 1'b0;
    en_translation_i = 1'b0;
    priv_lvl_i       = mmu_pkg::PRIV_S;
    sum_i            = 1'b0;
    satp_ppn_i       = '0;
    asid_i           = '0;
    flush_tlb_i      = 1'b0;
    flush_asid_i     = '0;
    lsu_req_i        = 1'b0;
    lsu_vaddr_i      = '0;
    lsu_is_store_i   = 1'b0;
    n_req            = 0;
    // M lines fill memory, the rest are commands in order
    fd = $fopen("mmu_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open mmu_tests.txt");
      errs++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        tag = line.substr(0, 0);
        if ((tag == "M") && ($sscanf(line, "M %h %h", v1, v2) == 2)) begin
          pte_mem[v1[`MMU_PLEN-1:0]] = v2;
        end else if ((tag == "R") || (tag == "T") || (tag == "F")) begin
          cmds.push_back(line);
          if (tag == "R") n_req++;
        end
      end
      $fclose(fd);
    end
    if (n_req == 0) begin
      $display("no request lines found in mmu_tests.txt");
      errs++;
    end
    limit = 200 * (n_req + 1);
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    foreach (cmds[i]) begin
      tag = cmds[i].substr(0, 0);
      if ((tag == "T") && ($sscanf(cmds[i], "T %h %h %h", v1, v2, v3) == 3)) begin
        set_mode(v1[0], v2[`MMU_PPNW-1:0], v3[`MMU_ASIDW-1:0]);
      end else if ((tag == "F") && ($sscanf(cmds[i], "F %h", v1) == 1)) begin
        flush_tlb(v1[`MMU_ASIDW-1:0]);
      end else if ((tag == "R")
          && ($sscanf(cmds[i], "R %h %h %h %h %h %h %h", v1, v2, v3, v4, v5, v6, v7) == 7)) begin
        run_request(v1[`MMU_VLEN-1:0], v2[0], v3[1:0], v4[0], v5[0],
                    v6[`MMU_PLEN-1:0], v7[3:0]);
      end else begin
        $display("malformed command line %0d in mmu_tests.txt", i);
        errs++;
      end
    end
    repeat (4) @(posedge clk_i);
    $display("requests %0d, passed %0d, failed %0d, errors %0d",
             n_run, n_run - n_fail, n_fail, errs);
    if (errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mmu_tests.txt
# M <pte byte addr> <pte> | T <translate> <satp ppn> <asid> | F <asid, 0 = all>
# R <vaddr> <store> <priv 0=U 1=S> <sum> <hit> <paddr> <cause>, hex, paddr unused on a fault
M 80000000 20000401
M 80000008 300000c7
M 80001000 20000801
M 80001008 280000c7
M 80002000 240000c7
M 80002008 24000443
M 80002010 24000847
M 80002018 24000cd7
M 80002020 24001087
M 80002028 0
M 80002030 240018e7
T 0 0 0
R 7f12345678 0 1 0 1 7f12345678 0
R 00000abcde 1 0 0 1 00000abcde 0
T 1 80000 1
R 00000123 0 1 0 0 90000123 0
R 00000456 1 1 0 1 90000456 0
R 00234567 0 1 0 0 a0034567 0
R 003ffff8 0 1 0 1 a01ffff8 0
R 52345678 1 1 0 0 d2345678 0
R 7ffffff0 0 1 0 1 fffffff0 0
R 00001010 1 1 0 0 0 f
R 00001020 0 1 0 1 90001020 0
R 00002000 1 1 0 0 0 f
R 00002008 0 1 0 1 90002008 0
R 00003000 0 1 0 0 0 d
R 00003000 0 1 1 1 90003000 0
R 00003004 1 0 0 1 90003004 0
R 00000123 0 0 0 0 0 d
R 00000128 1 0 0 1 0 f
R 00004000 0 1 0 0 0 d
R 00004000 1 1 0 0 0 f
R 00005000 0 1 0 0 0 d
R c0000000 1 1 0 0 0 f
R 00006000 0 1 0 0 90006000 0
R 00000123 0 1 0 1 90000123 0
F 1
R 00006010 0 1 0 1 90006010 0
R 00000123 0 1 0 0 90000123 0
F 2
R 00000124 0 1 0 1 90000124 0
F 0
R 00006000 0 1 0 0 90006000 0
R 00000123 0 1 0 0 90000123 0
T 1 80000 2
R 00006020 0 1 0 1 90006020 0
R 00000125 0 1 0 0 90000125 0
F 1
R 00000126 0 1 0 1 90000126 0
T 0 0 0
R 00000123 0 0 0 1 00000123 0

// File: flist.f
+incdir+.
mmu_pkg.sv
ptw_pkg.sv
mmu_tlb.sv
mmu_ptw.sv
mmu_check.sv
mmu_top.sv
tb_mmu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_mmu
FLIST     ?= flist.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FLIST))) mmu_cfg.svh
PASS_MSG  := All tests passed!

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
